// ==== led_panel_pkg.sv ====
/* panel geometry, scan and serial timing constants, command codes,
   shared structs for pixels, framebuffer writes, scan position and panel pins */
package led_panel_pkg;

    localparam int panel_cols         = 64;
    localparam int panel_rows         = 32;
    localparam int scan_rows          = 16;  // rows driven at once, top and bottom half
    localparam int color_bits         = 4;   // bitplanes per channel
    localparam int fb_addr_bits       = 11;  // row * 64 + column
    localparam int scan_div           = 4;   // clk_root cycles per column half period
    localparam int oe_base_cycles     = 8;   // oe length of plane 0
    localparam int uart_ticks_per_bit = 8;

    localparam int col_bits      = $clog2(panel_cols);
    localparam int row_bits      = $clog2(panel_rows);
    localparam int scan_row_bits = $clog2(scan_rows);
    localparam int plane_bits    = $clog2(color_bits);
    localparam int step_bits     = $clog2(scan_div);
    localparam int uart_tick_bits = $clog2(uart_ticks_per_bit);
    localparam int oe_cnt_bits   = $clog2(oe_base_cycles) + color_bits;  // holds 8 << 3

    localparam logic [7:0] cmd_write_pixel = 8'h57;
    localparam logic [7:0] cmd_brightness  = 8'h42;
    localparam logic [7:0] cmd_rgb_enable  = 8'h45;

    typedef struct packed {
        logic [color_bits-1:0] red;
        logic [color_bits-1:0] green;
        logic [color_bits-1:0] blue;
    } pixel_t;

    typedef struct packed {
        logic                    valid;
        logic [fb_addr_bits-1:0] addr;
        pixel_t                  pixel;
    } fb_write_t;

    typedef struct packed {
        logic [row_bits-1:0]   row;
        logic [col_bits-1:0]   col;
        logic [plane_bits-1:0] plane;
    } scan_pos_t;

    typedef struct packed {
        logic [2:0]            rgb_enable;         // bit 0 red, 1 green, 2 blue
        logic [color_bits-1:0] brightness_enable;  // one bit per plane
    } display_cfg_t;

    typedef struct packed {
        logic [2:0]               rgb_top;
        logic [2:0]               rgb_bottom;
        logic [scan_row_bits-1:0] row_addr;
        logic                     clk_pixel;
        logic                     row_latch;
        logic                     output_enable;
    } hub75_t;

endpackage

// ==== uart_rx.sv ====
/* 8N1 serial byte receiver with two-flop input synchronizer,
   mid-bit sampling and framing check */
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk_root,
    input  logic       arst_n,
    input  logic       rx_line,
    output logic [7:0] rx_byte,
    output logic       byte_strobe
);
    import led_panel_pkg::*;

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

    rx_state_t                 state;
    logic [1:0]                sync_q;
    logic [uart_tick_bits-1:0] tick_cnt;
    logic [2:0]                bit_cnt;
    logic [7:0]                shift_q;
    logic                      rx_in;
    logic                      bit_end;
    logic                      half_bit;

    assign rx_in    = sync_q[1];
    assign bit_end  = tick_cnt == uart_tick_bits'(uart_ticks_per_bit - 1);
    assign half_bit = tick_cnt == uart_tick_bits'(uart_ticks_per_bit / 2 - 1);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            sync_q      <= 2'b11;  // idle line is high
            state       <= st_idle;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            byte_strobe <= 1'b0;
        end else begin
            sync_q      <= {sync_q[0], rx_line};
            byte_strobe <= 1'b0;
            tick_cnt    <= tick_cnt + 1'b1;
            case (state)
                st_idle: begin
                    tick_cnt <= '0;
                    if (!rx_in) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (half_bit) begin
                        // glitch shorter than half a bit goes back to idle
                        state    <= rx_in ? st_idle : st_data;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                        end
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        byte_strobe <= rx_in;  // stop bit low means framing error
                        state       <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == st_data && bit_end) begin
            shift_q <= {rx_in, shift_q[7:1]};  // lsb first
        end
        if (state == st_stop && bit_end && rx_in) begin
            rx_byte <= shift_q;
        end
    end

endmodule

// ==== command_decoder.sv ====
/* command byte parser for pixel writes, brightness and colour enables */
`timescale 1ns/1ps

module command_decoder (
    input  logic                        clk_root,
    input  logic                        arst_n,
    input  logic [7:0]                  rx_byte,
    input  logic                        byte_strobe,
    output led_panel_pkg::fb_write_t    fb_write,
    output led_panel_pkg::display_cfg_t display_cfg
);
    import led_panel_pkg::*;

    typedef enum logic [2:0] {
        st_opcode,
        st_row,
        st_col,
        st_red,
        st_green_blue,
        st_bright,
        st_rgb
    } dec_state_t;

    dec_state_t              state;
    logic [row_bits-1:0]     row_q;
    logic [col_bits-1:0]     col_q;
    logic [color_bits-1:0]   red_q;
    logic                    wr_valid;
    logic [fb_addr_bits-1:0] wr_addr;
    pixel_t                  wr_pixel;

    assign fb_write = '{valid: wr_valid, addr: wr_addr, pixel: wr_pixel};

    // control path, byte count and settings
    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_opcode;
            wr_valid    <= 1'b0;
            display_cfg <= '{rgb_enable: 3'b111, brightness_enable: '1};
        end else begin
            wr_valid <= 1'b0;
            if (byte_strobe) begin
                case (state)
                    st_opcode: begin
                        case (rx_byte)
                            cmd_write_pixel: state <= st_row;
                            cmd_brightness:  state <= st_bright;
                            cmd_rgb_enable:  state <= st_rgb;
                            default:         state <= st_opcode;  // unknown, skip
                        endcase
                    end
                    st_row:        state <= st_col;
                    st_col:        state <= st_red;
                    st_red:        state <= st_green_blue;
                    st_green_blue: begin
                        wr_valid <= 1'b1;
                        state    <= st_opcode;
                    end
                    st_bright: begin
                        display_cfg.brightness_enable <= rx_byte[color_bits-1:0];
                        state <= st_opcode;
                    end
                    st_rgb: begin
                        display_cfg.rgb_enable <= rx_byte[2:0];
                        state <= st_opcode;
                    end
                    default: state <= st_opcode;
                endcase
            end
        end
    end

    // operand capture
    always_ff @(posedge clk_root) begin
        if (byte_strobe) begin
            case (state)
                st_row: row_q <= rx_byte[row_bits-1:0];
                st_col: col_q <= rx_byte[col_bits-1:0];
                st_red: red_q <= rx_byte[3:0];
                st_green_blue: begin
                    wr_addr  <= {row_q, col_q};  // row * 64 + col
                    wr_pixel <= '{red: red_q, green: rx_byte[7:4], blue: rx_byte[3:0]};
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== framebuffer_ram.sv ====
/* pixel memory, one write port and one synchronous read port */
`timescale 1ns/1ps

module framebuffer_ram (
    input  logic                                  clk_root,
    input  led_panel_pkg::fb_write_t              fb_write,
    input  logic [led_panel_pkg::fb_addr_bits-1:0] rd_addr,
    output led_panel_pkg::pixel_t                 rd_data
);
    import led_panel_pkg::*;

    pixel_t mem [2**fb_addr_bits];

    always_ff @(posedge clk_root) begin
        if (fb_write.valid) begin
            mem[fb_write.addr] <= fb_write.pixel;
        end
        rd_data <= mem[rd_addr];  // read old data on collision
    end

endmodule

// ==== framebuffer_fetch.sv ====
/* top and bottom pixel read per column, bitplane select and enable gating */
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                                   clk_root,
    input  logic                                   arst_n,
    input  led_panel_pkg::scan_pos_t               scan_pos,
    input  logic                                   load_start,
    input  led_panel_pkg::display_cfg_t            display_cfg,
    output logic [led_panel_pkg::fb_addr_bits-1:0] rd_addr,
    input  led_panel_pkg::pixel_t                  rd_data,
    output logic [2:0]                             rgb_top,
    output logic [2:0]                             rgb_bottom
);
    import led_panel_pkg::*;

    logic              load_d1;  // top pixel on rd_data, bottom address out
    logic              load_d2;  // bottom pixel on rd_data
    logic [2:0]        top_bits;
    logic [row_bits-1:0] rd_row;

    function automatic logic [2:0] select_plane(
        input pixel_t                px,
        input logic [plane_bits-1:0] plane,
        input display_cfg_t          cfg
    );
        logic [2:0] bits;
        bits = {px.blue[plane], px.green[plane], px.red[plane]};
        return bits & cfg.rgb_enable & {3{cfg.brightness_enable[plane]}};
    endfunction

    assign rd_row  = load_d1 ? scan_pos.row + row_bits'(scan_rows) : scan_pos.row;
    assign rd_addr = {rd_row, scan_pos.col};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            load_d1    <= 1'b0;
            load_d2    <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            load_d1 <= load_start;
            load_d2 <= load_d1;
            if (load_d2) begin
                // both halves change together
                rgb_top    <= top_bits;
                rgb_bottom <= select_plane(rd_data, scan_pos.plane, display_cfg);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (load_d1) begin
            top_bits <= select_plane(rd_data, scan_pos.plane, display_cfg);
        end
    end

endmodule

// ==== matrix_scan.sv ====
/* column, plane and row sequencer for the panel,
   pixel clock, row latch and binary weighted output enable */
`timescale 1ns/1ps

module matrix_scan (
    input  logic                      clk_root,
    input  logic                      arst_n,
    output led_panel_pkg::scan_pos_t  scan_pos,
    output logic                      load_start,
    input  logic [2:0]                rgb_top,
    input  logic [2:0]                rgb_bottom,
    output led_panel_pkg::hub75_t     panel
);
    import led_panel_pkg::*;

    typedef enum logic [1:0] {ph_shift, ph_wait, ph_latch} phase_t;

    phase_t                   phase;
    logic [step_bits-1:0]     step_cnt;
    logic                     half;     // second half of column, pixel clock high
    logic [col_bits-1:0]      col_q;
    logic [plane_bits-1:0]    plane_q;
    logic [scan_row_bits-1:0] row_q;
    logic [scan_row_bits-1:0] row_addr_q;
    logic [oe_cnt_bits-1:0]   oe_cnt;
    logic                     step_end;

    assign step_end   = step_cnt == step_bits'(scan_div - 1);
    assign load_start = phase == ph_shift && !half && step_cnt == '0;
    assign scan_pos   = '{row: row_bits'(row_q), col: col_q, plane: plane_q};

    assign panel = '{
        rgb_top:       rgb_top,
        rgb_bottom:    rgb_bottom,
        row_addr:      row_addr_q,
        clk_pixel:     phase == ph_shift && half,
        row_latch:     phase == ph_latch,
        output_enable: oe_cnt != '0
    };

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            phase      <= ph_shift;
            step_cnt   <= '0;
            half       <= 1'b0;
            col_q      <= '0;
            plane_q    <= '0;
            row_q      <= '0;
            row_addr_q <= '0;
            oe_cnt     <= '0;
        end else begin
            if (oe_cnt != '0) begin
                oe_cnt <= oe_cnt - 1'b1;
            end
            case (phase)
                ph_shift: begin
                    step_cnt <= step_end ? '0 : step_cnt + 1'b1;
                    if (step_end) begin
                        half <= ~half;
                        if (half) begin
                            col_q <= col_q + 1'b1;  // wraps to 0 after last column
                            if (col_q == col_bits'(panel_cols - 1)) begin
                                phase <= ph_wait;
                            end
                        end
                    end
                end
                ph_wait: begin
                    // previous line still lit, hold off the latch
                    if (oe_cnt == '0) begin
                        phase      <= ph_latch;
                        row_addr_q <= row_q;
                    end
                end
                ph_latch: begin
                    step_cnt <= step_end ? '0 : step_cnt + 1'b1;
                    if (step_end) begin
                        phase   <= ph_shift;
                        oe_cnt  <= oe_cnt_bits'(oe_base_cycles) << plane_q;
                        plane_q <= plane_q + 1'b1;
                        if (plane_q == plane_bits'(color_bits - 1)) begin
                            row_q <= row_q + 1'b1;  // wraps after row 15
                        end
                    end
                end
                default: phase <= ph_shift;
            endcase
        end
    end

endmodule

// ==== led_panel_top.sv ====
/* panel driver top: serial receiver, command decoder, framebuffer,
   fetch stage and scanner */
`timescale 1ns/1ps

module led_panel_top (
    input  logic                  clk_root,
    input  logic                  arst_n,
    input  logic                  rx_line,
    output led_panel_pkg::hub75_t panel
);
    import led_panel_pkg::*;

    logic [7:0]              rx_byte;
    logic                    byte_strobe;
    fb_write_t               fb_write;
    display_cfg_t            display_cfg;
    scan_pos_t               scan_pos;
    logic                    load_start;
    logic [fb_addr_bits-1:0] rd_addr;
    pixel_t                  rd_data;
    logic [2:0]              rgb_top;
    logic [2:0]              rgb_bottom;

    uart_rx u_uart_rx (
        .clk_root    (clk_root),
        .arst_n      (arst_n),
        .rx_line     (rx_line),
        .rx_byte     (rx_byte),
        .byte_strobe (byte_strobe)
    );

    command_decoder u_command_decoder (
        .clk_root    (clk_root),
        .arst_n      (arst_n),
        .rx_byte     (rx_byte),
        .byte_strobe (byte_strobe),
        .fb_write    (fb_write),
        .display_cfg (display_cfg)
    );

    framebuffer_ram u_framebuffer_ram (
        .clk_root (clk_root),
        .fb_write (fb_write),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    framebuffer_fetch u_framebuffer_fetch (
        .clk_root    (clk_root),
        .arst_n      (arst_n),
        .scan_pos    (scan_pos),
        .load_start  (load_start),
        .display_cfg (display_cfg),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rgb_top     (rgb_top),
        .rgb_bottom  (rgb_bottom)
    );

    matrix_scan u_matrix_scan (
        .clk_root   (clk_root),
        .arst_n     (arst_n),
        .scan_pos   (scan_pos),
        .load_start (load_start),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .panel      (panel)
    );

endmodule

// ==== tb_panel_ref.svh ====
/* testbench reference model: pixel shadow memory,
   expected panel bits per plane and xorshift generator */
`ifndef TB_PANEL_REF_SVH
`define TB_PANEL_REF_SVH

pixel_t      shadow_mem    [panel_rows*panel_cols];
bit          pixel_written [panel_rows*panel_cols];  // only these are compared bit for bit
logic [31:0] rng_state;

// 32 bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic void record_pixel(input int row, input int col, input pixel_t px);
    shadow_mem[row*panel_cols + col]    = px;
    pixel_written[row*panel_cols + col] = 1'b1;
endfunction

// bit 0 red, 1 green, 2 blue at the given plane, cleared when the
// channel or the whole plane is switched off
function automatic logic [2:0] expected_rgb(
    input pixel_t     px,
    input int         plane,
    input logic [2:0] rgb_en,
    input logic [3:0] bright_en
);
    logic [2:0] bits;
    int         ch;
    bits[0] = px.red[plane];
    bits[1] = px.green[plane];
    bits[2] = px.blue[plane];
    for (ch = 0; ch < 3; ch++) begin
        if (!rgb_en[ch] || !bright_en[plane]) begin
            bits[ch] = 1'b0;
        end
    end
    return bits;
endfunction

`endif

// ==== tb_led_panel.sv ====
/* clock and reset, serial driver, panel monitor with reference compare,
   scan structure checks and watchdog for the panel driver */
`timescale 1ns/1ps

module tb_led_panel;
    import led_panel_pkg::*;

    `include "tb_panel_ref.svh"

    logic       clk_root;
    logic       arst_n;
    logic       rx_line;
    hub75_t     panel;

    int         error_count;
    int         check_count;
    string      test_name;
    logic [2:0] exp_rgb_en;
    logic [3:0] exp_bright_en;
    bit         check_on;     // high while one full frame is compared
    int         frame_count;

    // monitor state for the scan order
    logic       prev_clk_pixel;
    logic       prev_latch;
    logic       prev_oe;
    int         col_cnt;
    int         plane_cnt;
    int         row_cnt;
    int         oe_len;
    int         oe_plane;

    led_panel_top u_dut (
        .clk_root (clk_root),
        .arst_n   (arst_n),
        .rx_line  (rx_line),
        .panel    (panel)
    );

    initial begin
        clk_root = 1'b0;
        forever #2 clk_root = ~clk_root;
    end

    task automatic check_bits(string what, logic [2:0] expected, logic [2:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Error %s: %s expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic check_value(string test, string what, logic [31:0] expected,
                               logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Error %s: %s expected %0d, actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic check_half(string half, int row, logic [2:0] actual);
        int         addr;
        logic [2:0] allowed;
        string      where;
        addr    = row*panel_cols + col_cnt;
        allowed = expected_rgb('1, plane_cnt, exp_rgb_en, exp_bright_en);
        where   = $sformatf("%s row %0d col %0d plane %0d", half, row, col_cnt, plane_cnt);
        if (allowed != 3'b111) begin
            // disabled bits must be dark even where nothing was written
            check_bits({where, " disabled bits"}, 3'b000, actual & ~allowed);
        end
        if (pixel_written[addr]) begin
            check_bits(where, expected_rgb(shadow_mem[addr], plane_cnt, exp_rgb_en,
                                           exp_bright_en), actual);
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clk_root) begin
        if (!arst_n) begin
            prev_clk_pixel = 1'b0;
            prev_latch     = 1'b0;
            prev_oe        = 1'b0;
            col_cnt        = 0;
            plane_cnt      = 0;
            row_cnt        = 0;
            oe_len         = 0;
            oe_plane       = 0;
            frame_count    = 0;
        end else begin
            if (panel.clk_pixel && !prev_clk_pixel) begin
                if (check_on) begin
                    check_half("top", row_cnt, panel.rgb_top);
                    check_half("bottom", row_cnt + scan_rows, panel.rgb_bottom);
                end
                col_cnt++;
            end
            if (panel.row_latch && !prev_latch) begin
                check_value("scan_structure", "pixel clocks per line", panel_cols, col_cnt);
                check_value("scan_structure", "row_addr at latch", row_cnt, panel.row_addr);
                oe_plane = plane_cnt;
                col_cnt  = 0;
                if (plane_cnt == color_bits - 1) begin
                    plane_cnt = 0;
                    if (row_cnt == scan_rows - 1) begin
                        row_cnt = 0;
                        frame_count++;
                    end else begin
                        row_cnt++;
                    end
                end else begin
                    plane_cnt++;
                end
            end
            if (panel.output_enable) begin
                oe_len++;
            end else if (prev_oe) begin
                check_value("scan_structure", "output_enable cycles",
                            oe_base_cycles << oe_plane, oe_len);
                oe_len = 0;
            end
            prev_clk_pixel = panel.clk_pixel;
            prev_latch     = panel.row_latch;
            prev_oe        = panel.output_enable;
        end
    end

    task automatic drive_bit(logic value);
        rx_line = value;
        repeat (uart_ticks_per_bit) @(negedge clk_root);
    endtask

    // 8N1, lsb first, two idle bits after the stop bit
    task automatic send_byte(logic [7:0] data);
        int b;
        @(negedge clk_root);
        drive_bit(1'b0);
        for (b = 0; b < 8; b++) begin
            drive_bit(data[b]);
        end
        drive_bit(1'b1);
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    task automatic send_pixel(logic [4:0] row, logic [5:0] col, pixel_t px);
        send_byte(cmd_write_pixel);
        send_byte({3'b000, row});
        send_byte({2'b00, col});
        send_byte({4'h0, px.red});
        send_byte({px.green, px.blue});
        record_pixel(row, col, px);
    endtask

    task automatic send_setting(logic [7:0] opcode, logic [7:0] value);
        send_byte(opcode);
        send_byte(value);
        if (opcode == cmd_rgb_enable) begin
            exp_rgb_en = value[2:0];
        end else if (opcode == cmd_brightness) begin
            exp_bright_en = value[3:0];
        end
    endtask

    // skip to the next frame start, then compare over one whole frame
    task automatic check_full_frame();
        int start_frame;
        start_frame = frame_count;
        while (frame_count == start_frame) @(posedge clk_root);
        check_on    = 1'b1;
        start_frame = frame_count;
        while (frame_count == start_frame) @(posedge clk_root);
        check_on = 1'b0;
    endtask

    task automatic send_random_pixel(bit bottom);
        logic [4:0] row;
        pixel_t     px;
        rng_state = xorshift32(rng_state);
        row       = rng_state[4:0];
        if (bottom) begin
            row[4] = 1'b1;
        end
        px = rng_state[22:11];
        send_pixel(row, rng_state[10:5], px);
    endtask

    initial begin
        int i;
        arst_n        = 1'b0;
        rx_line       = 1'b1;
        check_on      = 1'b0;
        error_count   = 0;
        check_count   = 0;
        exp_rgb_en    = 3'b111;
        exp_bright_en = 4'hf;
        rng_state     = 32'd42900;
        test_name     = "reset_values";
        repeat (16) begin
            @(negedge clk_root);
            check_bits("clk_pixel row_latch output_enable", 3'b000,
                       {panel.clk_pixel, panel.row_latch, panel.output_enable});
        end
        arst_n = 1'b1;
        repeat (3) begin
            @(negedge clk_root);
            check_bits("clk_pixel row_latch output_enable", 3'b000,
                       {panel.clk_pixel, panel.row_latch, panel.output_enable});
        end

        test_name = "random_writes";
        for (i = 0; i < 40; i++) begin
            send_random_pixel(i % 4 == 0);  // every fourth one forced to the bottom half
        end
        check_full_frame();

        test_name = "rgb_enable";
        send_setting(cmd_rgb_enable, 8'h05);  // red and blue only
        check_full_frame();

        test_name = "brightness";
        send_setting(cmd_rgb_enable, 8'h07);
        send_setting(cmd_brightness, 8'h05);  // planes 0 and 2
        check_full_frame();

        test_name = "unknown_opcode";
        send_setting(cmd_brightness, 8'h0f);
        send_byte(8'ha5);
        send_random_pixel(1'b0);
        check_full_frame();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        int bytes_sent;
        int frame_cycles;
        int limit;
        bytes_sent   = 41*5 + 4*2 + 1;  // pixel writes, settings, unknown opcode
        frame_cycles = scan_rows*color_bits*(panel_cols*2*scan_div + scan_div + 2);
        // twice the time of four stages of up to two frames each
        limit = 2*(16 + bytes_sent*12*uart_ticks_per_bit + 4*2*frame_cycles);
        repeat (limit) @(posedge clk_root);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
led_panel_pkg.sv
uart_rx.sv
command_decoder.sv
framebuffer_ram.sv
framebuffer_fetch.sv
matrix_scan.sv
led_panel_top.sv
tb_led_panel.sv

// ==== Bender.yml ====
package:
  name: led_panel

sources:
  - led_panel_pkg.sv
  - uart_rx.sv
  - command_decoder.sv
  - framebuffer_ram.sv
  - framebuffer_fetch.sv
  - matrix_scan.sv
  - led_panel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_led_panel.sv
